// File: files.f
hdl/rv_pkg.sv
hdl/rv_regfile.sv
hdl/rv_decoder.sv
hdl/rv_alu.sv
hdl/rv_pc_unit.sv
hdl/rv_mem_access.sv
hdl/rv_data_mem.sv
hdl/rv_core.sv
verification/rv_core_asserts.sv
verification/tb_clock.sv
verification/tb_core.sv

// File: hdl/rv_alu.sv
`default_nettype none

module rv_alu import rv_pkg::*; (
  input  logic [alu_op_w-1:0] i_op,
  input  logic [xlen-1:0]     i_a,
  input  logic [xlen-1:0]     i_b,
  input  logic [2:0]          i_funct3,
  output logic [xlen-1:0]     o_result,
  output logic                o_cond
);

  logic lt_s, lt_u, eq;

  // Comparisons shared by SLT/SLTU and the branches
  assign lt_s = $signed(i_a) < $signed(i_b);
  assign lt_u = i_a < i_b;
  assign eq = i_a == i_b;

  always_comb begin
    case (i_op)
      alu_add: o_result = i_a + i_b;
      alu_sub: o_result = i_a - i_b;
      alu_sll: o_result = i_a << i_b[4:0];
      alu_slt: o_result = {{(xlen-1){1'b0}}, lt_s};
      alu_sltu: o_result = {{(xlen-1){1'b0}}, lt_u};
      alu_xor: o_result = i_a ^ i_b;
      alu_srl: o_result = i_a >> i_b[4:0];
      alu_sra: o_result = $signed(i_a) >>> i_b[4:0];
      alu_or: o_result = i_a | i_b;
      alu_and: o_result = i_a & i_b;
      alu_pass_b: o_result = i_b;
      default: o_result = '0;
    endcase
  end

  // Branch condition by funct3
  always_comb begin
    case (i_funct3)
      3'b000: o_cond = eq;
      3'b001: o_cond = !eq;
      3'b100: o_cond = lt_s;
      3'b101: o_cond = !lt_s;
      3'b110: o_cond = lt_u;
      3'b111: o_cond = !lt_u;
      default: o_cond = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/rv_core.sv
`default_nettype none

module rv_core import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic [xlen-1:0] i_insn,
  output logic [xlen-1:0] o_pc,
  output store_t          o_store,
  output logic            o_halt
);

  ctrl_t ctrl;
  store_t st;
  logic [xlen-1:0] rs1_data, rs2_data, alu_a, alu_b, alu_result;
  logic [xlen-1:0] pc, pc_plus4, load_word, wb_data;
  logic cond, wb_en;

  // Operand selection
  assign alu_a = ctrl.use_pc ? pc : rs1_data;
  assign alu_b = ctrl.use_imm ? ctrl.imm : rs2_data;

  assign o_pc = pc;
  assign o_store = st;
  assign o_halt = ctrl.is_halt;

  rv_decoder decoder_i (.i_insn(i_insn), .o_ctrl(ctrl));

  rv_regfile regfile_i (
    .clk(clk), .rst(rst),
    .i_rs1(ctrl.rs1), .i_rs2(ctrl.rs2), .i_rd(ctrl.rd),
    .i_we(wb_en), .i_wdata(wb_data),
    .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
  );

  rv_alu alu_i (
    .i_op(ctrl.alu_op), .i_a(alu_a), .i_b(alu_b), .i_funct3(ctrl.funct3),
    .o_result(alu_result), .o_cond(cond)
  );

  rv_pc_unit pc_unit_i (
    .clk(clk), .rst(rst), .i_ctrl(ctrl), .i_cond(cond), .i_rs1_data(rs1_data),
    .o_pc(pc), .o_pc_plus4(pc_plus4)
  );

  rv_mem_access mem_access_i (
    .i_ctrl(ctrl), .i_addr(alu_result), .i_rs2_data(rs2_data),
    .i_load_word(load_word), .i_pc_plus4(pc_plus4),
    .o_store(st), .o_wb_data(wb_data), .o_wb_en(wb_en)
  );

  rv_data_mem data_mem_i (.clk(clk), .i_store(st), .o_load_word(load_word));

endmodule

`default_nettype wire

// File: hdl/rv_data_mem.sv
`default_nettype none

module rv_data_mem import rv_pkg::*; #(
  parameter int dmem_words = 256
) (
  input  logic            clk,
  input  store_t          i_store,
  output logic [xlen-1:0] o_load_word
);

  logic [xlen-1:0] mem [dmem_words];
  logic [$clog2(dmem_words)-1:0] idx;

  // Word index from the bits above the byte offset
  assign idx = i_store.addr[$clog2(dmem_words)+1:2];

  assign o_load_word = mem[idx];

  always_ff @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (i_store.strobe[b]) begin
        mem[idx][8*b +: 8] <= i_store.data[8*b +: 8];
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/rv_decoder.sv
`default_nettype none

module rv_decoder import rv_pkg::*; (
  input  insn_t i_insn,
  output ctrl_t o_ctrl
);

  logic [xlen-1:0] imm_i, imm_s, imm_b, imm_j, imm_u;
  logic [alu_op_w-1:0] arith_op;
  logic f7_is_alt;

  assign imm_i = {{20{i_insn.i_fmt.imm[11]}}, i_insn.i_fmt.imm};
  assign imm_s = {{20{i_insn.s_fmt.imm_hi[6]}}, i_insn.s_fmt.imm_hi, i_insn.s_fmt.imm_lo};
  assign imm_b = {{19{i_insn.s_fmt.imm_hi[6]}}, i_insn.s_fmt.imm_hi[6], i_insn.s_fmt.imm_lo[0],
                  i_insn.s_fmt.imm_hi[5:0], i_insn.s_fmt.imm_lo[4:1], 1'b0};
  assign imm_j = {{11{i_insn.u_fmt.imm[19]}}, i_insn.u_fmt.imm[19], i_insn.u_fmt.imm[7:0],
                  i_insn.u_fmt.imm[8], i_insn.u_fmt.imm[18:9], 1'b0};
  assign imm_u = {i_insn.u_fmt.imm, 12'h000};

  assign f7_is_alt = i_insn.r_fmt.funct7 == f7_alt;

  // SUB only exists in the register form; SRAI shares the funct7 slot
  always_comb begin
    case (i_insn.r_fmt.funct3)
      3'b000: begin
        arith_op = (i_insn.r_fmt.opcode == op_reg_reg && f7_is_alt) ? alu_sub : alu_add;
      end
      3'b001: arith_op = alu_sll;
      3'b010: arith_op = alu_slt;
      3'b011: arith_op = alu_sltu;
      3'b100: arith_op = alu_xor;
      3'b101: arith_op = f7_is_alt ? alu_sra : alu_srl;
      3'b110: arith_op = alu_or;
      default: arith_op = alu_and;
    endcase
  end

  always_comb begin
    o_ctrl = '0;
    o_ctrl.rd = i_insn.r_fmt.rd;
    o_ctrl.rs1 = i_insn.r_fmt.rs1;
    o_ctrl.rs2 = i_insn.r_fmt.rs2;
    o_ctrl.funct3 = i_insn.r_fmt.funct3;
    o_ctrl.imm = imm_i;
    o_ctrl.alu_op = alu_add;
    case (i_insn.r_fmt.opcode)
      op_lui: begin
        o_ctrl.imm = imm_u;
        o_ctrl.alu_op = alu_pass_b;
        o_ctrl.use_imm = 1'b1;
        o_ctrl.reg_we = 1'b1;
      end
      op_auipc: begin
        o_ctrl.imm = imm_u;
        o_ctrl.use_imm = 1'b1;
        o_ctrl.use_pc = 1'b1;
        o_ctrl.reg_we = 1'b1;
      end
      op_jal: begin
        o_ctrl.imm = imm_j;
        o_ctrl.use_imm = 1'b1;
        o_ctrl.use_pc = 1'b1;
        o_ctrl.reg_we = 1'b1;
        o_ctrl.is_jal = 1'b1;
      end
      op_jalr: begin
        o_ctrl.use_imm = 1'b1;
        o_ctrl.reg_we = 1'b1;
        o_ctrl.is_jalr = 1'b1;
      end
      op_branch: begin
        // Compare rs1 with rs2, target formed in the PC unit
        o_ctrl.imm = imm_b;
        o_ctrl.is_branch = 1'b1;
      end
      op_load: begin
        o_ctrl.use_imm = 1'b1;
        o_ctrl.reg_we = 1'b1;
        o_ctrl.is_load = 1'b1;
      end
      op_store: begin
        o_ctrl.imm = imm_s;
        o_ctrl.use_imm = 1'b1;
        o_ctrl.is_store = 1'b1;
      end
      op_reg_imm: begin
        o_ctrl.alu_op = arith_op;
        o_ctrl.use_imm = 1'b1;
        o_ctrl.reg_we = 1'b1;
      end
      op_reg_reg: begin
        o_ctrl.alu_op = arith_op;
        o_ctrl.reg_we = 1'b1;
      end
      op_system: begin
        // Only ECALL halts, with every other field zero
        o_ctrl.is_halt = i_insn.i_fmt.imm == '0 && i_insn.i_fmt.rs1 == '0 &&
                         i_insn.i_fmt.funct3 == '0 && i_insn.i_fmt.rd == '0;
      end
      op_misc_mem: begin
        // FENCE has no effect on a single-cycle core
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/rv_mem_access.sv
`default_nettype none

module rv_mem_access import rv_pkg::*; (
  input  ctrl_t           i_ctrl,
  input  logic [xlen-1:0] i_addr,
  input  logic [xlen-1:0] i_rs2_data,
  input  logic [xlen-1:0] i_load_word,
  input  logic [xlen-1:0] i_pc_plus4,
  output store_t          o_store,
  output logic [xlen-1:0] o_wb_data,
  output logic            o_wb_en
);

  logic [1:0] offs;
  logic misaligned;
  logic [xlen-1:0] lane, load_val;

  assign offs = i_addr[1:0];
  // Addressed byte moved down to bit 0
  assign lane = i_load_word >> {offs, 3'b000};

  // funct3[1:0] is the access size; size 3 is not part of RV32I
  always_comb begin
    case (i_ctrl.funct3[1:0])
      2'b00: misaligned = 1'b0;
      2'b01: misaligned = offs[0];
      2'b10: misaligned = |offs;
      default: misaligned = 1'b1;
    endcase
  end

  always_comb begin
    o_store.addr = {i_addr[xlen-1:2], 2'b00};
    o_store.data = '0;
    o_store.strobe = '0;
    if (i_ctrl.is_store && !misaligned) begin
      case (i_ctrl.funct3[1:0])
        2'b00: begin
          o_store.strobe = 4'b0001 << offs;
          o_store.data = {24'h0, i_rs2_data[7:0]} << {offs, 3'b000};
        end
        2'b01: begin
          o_store.strobe = 4'b0011 << offs;
          o_store.data = {16'h0, i_rs2_data[15:0]} << {offs, 3'b000};
        end
        default: begin
          o_store.strobe = 4'b1111;
          o_store.data = i_rs2_data;
        end
      endcase
    end
  end

  // funct3[2] marks the unsigned loads
  always_comb begin
    case (i_ctrl.funct3[1:0])
      2'b00: load_val = {{24{lane[7] & ~i_ctrl.funct3[2]}}, lane[7:0]};
      2'b01: load_val = {{16{lane[15] & ~i_ctrl.funct3[2]}}, lane[15:0]};
      default: load_val = i_load_word;
    endcase
  end

  assign o_wb_en = i_ctrl.reg_we && !(i_ctrl.is_load && misaligned);

  always_comb begin
    if (i_ctrl.is_jal || i_ctrl.is_jalr) begin
      o_wb_data = i_pc_plus4;
    end else if (i_ctrl.is_load) begin
      o_wb_data = load_val;
    end else begin
      o_wb_data = i_addr;
    end
  end

endmodule

`default_nettype wire

// File: hdl/rv_pc_unit.sv
`default_nettype none

module rv_pc_unit import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  ctrl_t           i_ctrl,
  input  logic            i_cond,
  input  logic [xlen-1:0] i_rs1_data,
  output logic [xlen-1:0] o_pc,
  output logic [xlen-1:0] o_pc_plus4
);

  logic [xlen-1:0] pc_q, pc_next, jalr_sum;

  assign o_pc = pc_q;
  assign o_pc_plus4 = pc_q + xlen'(4);
  assign jalr_sum = i_rs1_data + i_ctrl.imm;

  always_comb begin
    if (i_ctrl.is_halt) begin
      pc_next = pc_q;
    end else if (i_ctrl.is_jal || (i_ctrl.is_branch && i_cond)) begin
      pc_next = pc_q + i_ctrl.imm;
    end else if (i_ctrl.is_jalr) begin
      // Keep fetch word aligned
      pc_next = {jalr_sum[xlen-1:2], 2'b00};
    end else begin
      pc_next = o_pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_next;
    end
  end

endmodule

`default_nettype wire

// File: hdl/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  // Major opcodes
  localparam logic [6:0] op_load = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jalr = 7'b1100111;
  localparam logic [6:0] op_jal = 7'b1101111;
  localparam logic [6:0] op_misc_mem = 7'b0001111;
  localparam logic [6:0] op_reg_imm = 7'b0010011;
  localparam logic [6:0] op_reg_reg = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;
  localparam logic [6:0] op_auipc = 7'b0010111;
  localparam logic [6:0] op_lui = 7'b0110111;

  // Selects SUB and SRA/SRAI
  localparam logic [6:0] f7_alt = 7'b0100000;

  localparam int alu_op_w = 4;
  localparam logic [alu_op_w-1:0] alu_add = 4'd0;
  localparam logic [alu_op_w-1:0] alu_sub = 4'd1;
  localparam logic [alu_op_w-1:0] alu_sll = 4'd2;
  localparam logic [alu_op_w-1:0] alu_slt = 4'd3;
  localparam logic [alu_op_w-1:0] alu_sltu = 4'd4;
  localparam logic [alu_op_w-1:0] alu_xor = 4'd5;
  localparam logic [alu_op_w-1:0] alu_srl = 4'd6;
  localparam logic [alu_op_w-1:0] alu_sra = 4'd7;
  localparam logic [alu_op_w-1:0] alu_or = 4'd8;
  localparam logic [alu_op_w-1:0] alu_and = 4'd9;
  localparam logic [alu_op_w-1:0] alu_pass_b = 4'd10;

  // One instruction word seen through each encoding format
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [reg_addr_w-1:0] rs2;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } r_fmt;
    struct packed {
      logic [11:0]           imm;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } i_fmt;
    // B immediates come from this view too
    struct packed {
      logic [6:0]            imm_hi;
      logic [reg_addr_w-1:0] rs2;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [4:0]            imm_lo;
      logic [6:0]            opcode;
    } s_fmt;
    // J immediates come from this view too
    struct packed {
      logic [19:0]           imm;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } u_fmt;
  } insn_t;

  typedef struct packed {
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       imm;
    logic [alu_op_w-1:0]   alu_op;
    logic                  use_imm;
    logic                  use_pc;
    logic                  reg_we;
    logic                  is_load;
    logic                  is_store;
    logic                  is_branch;
    logic                  is_jal;
    logic                  is_jalr;
    logic                  is_halt;
    logic [2:0]            funct3;
  } ctrl_t;

  typedef struct packed {
    logic [xlen-1:0] addr;
    logic [xlen-1:0] data;
    logic [3:0]      strobe;
  } store_t;

endpackage

`default_nettype wire

// File: hdl/rv_regfile.sv
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [reg_addr_w-1:0] i_rs1,
  input  logic [reg_addr_w-1:0] i_rs2,
  input  logic [reg_addr_w-1:0] i_rd,
  input  logic                  i_we,
  input  logic [xlen-1:0]       i_wdata,
  output logic [xlen-1:0]       o_rs1_data,
  output logic [xlen-1:0]       o_rs2_data
);

  logic [xlen-1:0] regs [2**reg_addr_w];

  // Entry 0 is cleared by reset and never written, so x0 reads zero
  assign o_rs1_data = regs[i_rs1];
  assign o_rs2_data = regs[i_rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_rd != '0) begin
      regs[i_rd] <= i_wdata;
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --top-module tb_core -f files.f -o sim_core

output=$(./obj_dir/sim_core)
echo "$output"

if echo "$output" | grep -qx "sim passed"; then
  exit 0
fi
exit 1

// File: verification/rv_core_asserts.sv
`default_nettype none

module rv_core_asserts import rv_pkg::*; (
  input logic            clk,
  input logic            rst,
  input logic [xlen-1:0] i_pc,
  input store_t          i_store,
  input logic            i_halt
);

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) i_pc[1:0] == 2'b00)
    else $error("PC is not word aligned: %h", i_pc);

  // Byte, halfword or word lanes only
  a_strobe_legal: assert property (@(posedge clk) disable iff (rst)
    i_store.strobe inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                           4'b0011, 4'b1100, 4'b1111})
    else $error("Illegal store strobe %b", i_store.strobe);

  a_halt_holds_pc: assert property (@(posedge clk) disable iff (rst) i_halt |=> $stable(i_pc))
    else $error("PC moved while halted");

endmodule

bind rv_core rv_core_asserts core_asserts_i (
  .clk(clk), .rst(rst), .i_pc(o_pc), .i_store(o_store), .i_halt(o_halt)
);

`default_nettype wire

// File: verification/tb_clock.sv
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Reset spans the first 16 rising edges
  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: verification/tb_core.sv
`default_nettype none

module tb_core import rv_pkg::*; ();

  localparam logic [31:0] nop_word = 32'h0000_0013;
  localparam int prog_len = 256;
  localparam int cycle_limit = (prog_len + 8) * 2 + 16;
  localparam logic [31:0] marker = 32'h5a5a_a5a5;

  logic clk, rst;
  logic [xlen-1:0] i_insn, o_pc;
  store_t o_store;
  logic o_halt;

  logic [31:0] prog [prog_len];
  store_t exp_q[$];
  int grp_q[$];
  int seed = 32'h0c34_6d96;
  int n_insn = 0, cur_grp = 0, exp_idx = 0, checks = 0, fails = 0;
  int grp_fails0 = 0, cycle = 0, halt_cycles = 0;
  logic [31:0] next_addr, ecall_pc;
  logic finished = 1'b0;

  tb_clock clock_i (.clk(clk), .rst(rst));

  rv_core rv_core_i (
    .clk(clk), .rst(rst), .i_insn(i_insn), .o_pc(o_pc), .o_store(o_store), .o_halt(o_halt)
  );

  always @(posedge clk) cycle <= cycle + 1;

  // Instruction encoders
  function automatic logic [31:0] reg_op(logic [6:0] f7, logic [4:0] rs2, rs1,
                                         logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_reg_reg};
  endfunction

  function automatic logic [31:0] imm_op(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] store_op(logic [11:0] imm, logic [4:0] rs2, rs1,
                                           logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] branch_op(logic [12:0] imm, logic [4:0] rs2, rs1,
                                            logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic logic [31:0] upper_op(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] jal_op(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  // Reference results from the RV32I definitions
  function automatic logic [31:0] alu_model(logic [2:0] f3, logic alt, logic [31:0] a, b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'h0, $signed(a) < $signed(b)};
      3'd3: return {31'h0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(logic [2:0] f3, logic [31:0] a, b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic string group_name(int g);
    case (g)
      1: return "ALU";
      2: return "LUI/AUIPC";
      3: return "byte and halfword access";
      4: return "branches";
      5: return "JAL/JALR";
      default: return "ECALL halt";
    endcase
  endfunction

  task automatic emit(input logic [31:0] w);
    prog[n_insn] = w;
    n_insn++;
  endtask

  task automatic store_at(input logic [2:0] f3, input logic [4:0] rs2,
                          input logic [31:0] addr, data, input logic [3:0] strobe);
    store_t e;
    emit(store_op(addr[11:0], rs2, 5'd0, f3));
    e.addr = {addr[31:2], 2'b00};
    e.data = data;
    e.strobe = strobe;
    exp_q.push_back(e);
    grp_q.push_back(cur_grp);
  endtask

  task automatic expect_sw(input logic [4:0] rs2, input logic [31:0] data);
    store_at(3'b010, rs2, next_addr, data, 4'hf);
    next_addr = next_addr + 32'd4;
  endtask

  // Marker store that a jump or taken branch must step over
  task automatic skip_marker();
    emit(store_op(next_addr[11:0], 5'd8, 5'd0, 3'b010));
  endtask

  task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800;
    emit(upper_op(hi[31:12], rd, op_lui));
    emit(imm_op(v[11:0], rd, 3'b000, rd, op_reg_imm));
  endtask

  task automatic build_program();
    logic [31:0] a, b, v, w, p;
    logic [11:0] imm;
    logic [19:0] u;
    logic [4:0] r1, r2;
    for (int i = 0; i < prog_len; i++) prog[i] = nop_word;
    next_addr = 32'h100;
    cur_grp = 1;
    // Negative A and positive B keep signed and unsigned results apart
    a = $random(seed) | 32'h8000_0000;
    b = $random(seed) & 32'h7fff_ffff;
    load_reg(5'd1, a);
    load_reg(5'd2, b);
    for (int f = 0; f < 8; f++) begin
      for (int alt = 0; alt < 2; alt++) begin
        if (alt == 1 && f != 0 && f != 5) continue;
        emit(reg_op(alt == 1 ? f7_alt : 7'h00, 5'd2, 5'd1, 3'(f), 5'd3));
        expect_sw(5'd3, alu_model(3'(f), alt == 1, a, b));
        // No SUBI exists
        if (alt == 1 && f == 0) continue;
        imm = 12'($random(seed));
        if (f == 1 || f == 5) imm = {alt == 1 ? f7_alt : 7'h00, imm[4:0]};
        emit(imm_op(imm, 5'd1, 3'(f), 5'd3, op_reg_imm));
        expect_sw(5'd3, alu_model(3'(f), alt == 1, a, {{20{imm[11]}}, imm}));
      end
    end
    emit(imm_op(12'd5, 5'd0, 3'b000, 5'd0, op_reg_imm));
    expect_sw(5'd0, 32'h0);
    cur_grp = 2;
    u = 20'($random(seed));
    emit(upper_op(u, 5'd13, op_lui));
    expect_sw(5'd13, {u, 12'h000});
    p = 32'(4 * n_insn);
    emit(upper_op(u, 5'd14, op_auipc));
    expect_sw(5'd14, p + {u, 12'h000});
    // Bits 7 and 15 set so the signed loads must extend ones
    cur_grp = 3;
    v = $random(seed) | 32'h0000_8080;
    // Odd lanes come from x9 so neighboring bytes and halves differ
    w = v ^ 32'h0000_7f7f;
    load_reg(5'd4, v);
    load_reg(5'd9, w);
    for (int k = 0; k < 4; k++) begin
      store_at(3'b000, (k % 2) ? 5'd9 : 5'd4, 32'(32'h300 + k),
               32'((k % 2) ? w[7:0] : v[7:0]) << (8 * k), 4'(1 << k));
    end
    for (int h = 0; h < 2; h++) begin
      store_at(3'b001, h ? 5'd9 : 5'd4, 32'(32'h304 + 2 * h),
               32'(h ? w[15:0] : v[15:0]) << (16 * h), 4'(3 << (2 * h)));
    end
    emit(imm_op(12'h301, 5'd0, 3'b000, 5'd5, op_load));
    expect_sw(5'd5, {{24{w[7]}}, w[7:0]});
    emit(imm_op(12'h302, 5'd0, 3'b100, 5'd5, op_load));
    expect_sw(5'd5, {24'h0, v[7:0]});
    emit(imm_op(12'h306, 5'd0, 3'b001, 5'd5, op_load));
    expect_sw(5'd5, {{16{w[15]}}, w[15:0]});
    emit(imm_op(12'h304, 5'd0, 3'b101, 5'd5, op_load));
    expect_sw(5'd5, {16'h0, v[15:0]});
    // x6 is all ones, x7 is one
    cur_grp = 4;
    load_reg(5'd6, 32'hffff_ffff);
    load_reg(5'd7, 32'h0000_0001);
    load_reg(5'd8, marker);
    for (int f = 0; f < 8; f++) begin
      if (f == 2 || f == 3) continue;
      for (int pair = 0; pair < 3; pair++) begin
        r1 = (pair == 2) ? 5'd7 : 5'd6;
        r2 = (pair == 1) ? 5'd7 : 5'd6;
        emit(branch_op(13'd8, r2, r1, 3'(f)));
        if (branch_taken(3'(f), r1 == 5'd6 ? 32'hffff_ffff : 32'd1,
                         r2 == 5'd6 ? 32'hffff_ffff : 32'd1)) begin
          skip_marker();
        end else begin
          expect_sw(5'd7, 32'd1);
        end
        expect_sw(5'd6, 32'hffff_ffff);
      end
    end
    cur_grp = 5;
    p = 32'(4 * n_insn);
    emit(jal_op(21'd12, 5'd10));
    skip_marker();
    skip_marker();
    expect_sw(5'd10, p + 32'd4);
    p = 32'(4 * n_insn);
    emit(upper_op(20'h0, 5'd11, op_auipc));
    emit(imm_op(12'd16, 5'd11, 3'b000, 5'd12, op_jalr));
    skip_marker();
    skip_marker();
    expect_sw(5'd12, p + 32'd8);
    ecall_pc = 32'(4 * n_insn);
    emit({25'h0, op_system});
  endtask

  task automatic compare(input string name, input logic [31:0] got, exp);
    checks++;
    assert (got === exp) else begin
      $display("Fail %0t %s expected %h got %h", $time, name, exp, got);
      fails++;
    end
  endtask

  task automatic require(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      $display("Error at %0t: %s", $time, what);
      fails++;
    end
  endtask

  task automatic report_group(input int g);
    $display("Test %0d (%s) finished with %0d errors", g, group_name(g), fails - grp_fails0);
    grp_fails0 = fails;
  endtask

  task automatic match_store();
    store_t e;
    if (o_store.strobe == 4'h0) return;
    require(exp_idx < exp_q.size(), $sformatf("store to %h was not expected", o_store.addr));
    if (exp_idx >= exp_q.size()) return;
    e = exp_q[exp_idx];
    compare("o_store.addr", o_store.addr, e.addr);
    compare("o_store.data", o_store.data, e.data);
    compare("o_store.strobe", 32'(o_store.strobe), 32'(e.strobe));
    exp_idx++;
    if (exp_idx == exp_q.size() || grp_q[exp_idx] != grp_q[exp_idx - 1]) begin
      report_group(grp_q[exp_idx - 1]);
    end
  endtask

  // Halt must rise at the ECALL and hold the PC for 8 more cycles
  task automatic track_halt();
    if (o_halt) begin
      compare("o_pc", o_pc, ecall_pc);
      halt_cycles++;
    end else if (halt_cycles > 0) begin
      require(1'b0, "o_halt fell after the ECALL");
      finished = 1'b1;
    end
    if (halt_cycles == 9) begin
      report_group(6);
      finished = 1'b1;
    end
  endtask

  initial begin
    i_insn = nop_word;
    build_program();
    @(negedge rst);
    while (!finished && cycle < cycle_limit) begin
      i_insn = (o_pc[31:10] == '0) ? prog[o_pc[9:2]] : nop_word;
      @(negedge clk);
      match_store();
      track_halt();
      @(posedge clk);
      #1;
    end
    require(finished, "timeout, the core did not halt within the cycle limit");
    require(exp_idx == exp_q.size(),
            $sformatf("%0d expected stores never appeared", exp_q.size() - exp_idx));
    $display("%0d checks passed, %0d checks failed", checks - fails, fails);
    if (fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
